// ==== tlb_entry_pkg.sv ====
// TLB geometry constants
// Entry word formats and the register data word union

`default_nettype none

package tlb_entry_pkg;

	// ========================================
	// Geometry
	// ========================================
	localparam int TLB_WAYS       = 4;
	localparam int TLB_WAY_BITS   = 2;
	localparam int TLB_ENTRIES    = 64;
	localparam int TLB_INDEX_BITS = 6;
	// 16 KiB pages
	localparam int PAGE_BITS      = 14;
	localparam int TAG_BITS       = 12;
	localparam int ASID_BITS      = 8;
	localparam int PPN_BITS       = 18;

	typedef logic [ASID_BITS-1:0] asid_t;

	// ========================================
	// Entry words
	// ========================================
	// rwx is read, write, execute from msb down
	typedef struct packed {
		logic                v;
		logic                g;
		logic [2:0]          rwx;
		logic [8:0]          pad;
		logic [PPN_BITS-1:0] ppn;
	} pte_t;

	typedef struct packed {
		asid_t               asid;
		logic [11:0]         pad;
		logic [TAG_BITS-1:0] tag;
	} vpn_t;

	// Register data word, PTE view at address 0 and VPN view at address 1
	typedef union packed {
		pte_t pte;
		vpn_t vpn;
	} tlb_word_u;

	// One way stores this per index
	typedef struct packed {
		pte_t pte;
		vpn_t vpn;
	} tlb_entry_t;

endpackage

`default_nettype wire

// ==== stlb_bus_pkg.sv ====
// Channel count and address widths
// Register port addresses and control word fields

`default_nettype none

package stlb_bus_pkg;

	localparam int CHANNELS = 4;
	localparam int CH_BITS  = 2;

	localparam int VADR_BITS = 32;
	localparam int PADR_BITS = 32;

	typedef logic [VADR_BITS-1:0] vadr_t;
	typedef logic [PADR_BITS-1:0] padr_t;

	// ========================================
	// Register port
	// ========================================
	localparam int REG_ADDR_BITS = 2;

	localparam logic [REG_ADDR_BITS-1:0] REG_PTE  = 2'd0;
	localparam logic [REG_ADDR_BITS-1:0] REG_VPN  = 2'd1;
	localparam logic [REG_ADDR_BITS-1:0] REG_CTRL = 2'd2;

	// Control word layout
	localparam int CTRL_INDEX_LSB = 0;
	localparam int CTRL_WAY_LSB   = 8;
	localparam int CTRL_WRITE_BIT = 16;
	localparam int CTRL_CLEAR_BIT = 17;

endpackage

`default_nettype wire

// ==== tlb_way_ram.sv ====
// One TLB way
// Dual-port RAM, synchronous write and registered read

`default_nettype none
`timescale 1ns/1ps

module tlb_way_ram (
	input  logic                                    clk_g,
	input  logic                                    wr_en_i,
	input  logic [tlb_entry_pkg::TLB_INDEX_BITS-1:0] wr_index_i,
	input  tlb_entry_pkg::tlb_entry_t                wr_entry_i,
	input  logic                                    rd_en_i,
	input  logic [tlb_entry_pkg::TLB_INDEX_BITS-1:0] rd_index_i,
	output tlb_entry_pkg::tlb_entry_t                rd_entry_o
);

	import tlb_entry_pkg::*;

	tlb_entry_t mem [TLB_ENTRIES];

	// Write port, owned by the maintenance unit
	always_ff @(posedge clk_g) begin
		if (wr_en_i)
			mem[wr_index_i] <= wr_entry_i;
	end

	// Read port, data one cycle after the enable
	always_ff @(posedge clk_g) begin
		if (rd_en_i)
			rd_entry_o <= mem[rd_index_i];
	end

endmodule

`default_nettype wire

// ==== channel_arbiter.sv ====
// Round-robin arbiter for the lookup pipeline
// In-flight mask keeps a channel from a second lookup

`default_nettype none
`timescale 1ns/1ps

module channel_arbiter (
	input  logic                               clk_g,
	input  logic                               rst_i,
	input  logic [stlb_bus_pkg::CHANNELS-1:0]  req_i,
	input  logic                               retire_valid_i,
	input  logic [stlb_bus_pkg::CH_BITS-1:0]   retire_channel_i,
	output logic                               grant_valid_o,
	output logic [stlb_bus_pkg::CH_BITS-1:0]   grant_channel_o
);

	import stlb_bus_pkg::*;

	logic [CHANNELS-1:0] in_flight;
	logic [CHANNELS-1:0] in_flight_next;
	logic [CHANNELS-1:0] eligible;
	logic [CH_BITS-1:0]  last_grant;
	logic                pick_valid;
	logic [CH_BITS-1:0]  pick_channel;

	assign eligible = req_i & ~in_flight;

	// Search starts one past the last grant and wraps
	always_comb begin
		logic [CH_BITS-1:0] cand;
		pick_valid   = 1'b0;
		pick_channel = last_grant;
		for (int i = 1; i <= CHANNELS; i++) begin
			cand = last_grant + CH_BITS'(i);
			if (!pick_valid && eligible[cand]) begin
				pick_valid   = 1'b1;
				pick_channel = cand;
			end
		end
	end

	// A retiring channel is never granted in the same cycle
	always_comb begin
		in_flight_next = in_flight;
		if (retire_valid_i)
			in_flight_next[retire_channel_i] = 1'b0;
		if (pick_valid)
			in_flight_next[pick_channel] = 1'b1;
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			in_flight       <= '0;
			// Channel 0 is searched first
			last_grant      <= CH_BITS'(CHANNELS-1);
			grant_valid_o   <= 1'b0;
			grant_channel_o <= '0;
		end else begin
			in_flight     <= in_flight_next;
			grant_valid_o <= pick_valid;
			if (pick_valid) begin
				grant_channel_o <= pick_channel;
				last_grant      <= pick_channel;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tlb_lookup.sv ====
// Two-stage TLB lookup pipeline
// Tag and ASID compare, address translation, write permission

`default_nettype none
`timescale 1ns/1ps

module tlb_lookup (
	input  logic                                              clk_g,
	input  logic                                              rst_i,
	input  logic                                              grant_valid_i,
	input  logic [stlb_bus_pkg::CH_BITS-1:0]                  grant_channel_i,
	input  stlb_bus_pkg::vadr_t                               vadr_i,
	input  tlb_entry_pkg::asid_t                              asid_i,
	input  logic                                              we_i,
	output logic                                              rd_en_o,
	output logic [tlb_entry_pkg::TLB_INDEX_BITS-1:0]          rd_index_o,
	input  tlb_entry_pkg::tlb_entry_t [tlb_entry_pkg::TLB_WAYS-1:0] way_entry_i,
	output logic                                              res_valid_o,
	output logic [stlb_bus_pkg::CH_BITS-1:0]                  res_channel_o,
	output logic                                              res_hit_o,
	output stlb_bus_pkg::padr_t                               res_padr_o,
	output logic [2:0]                                        res_rwx_o,
	output logic                                              res_we_o
);

	import tlb_entry_pkg::*;
	import stlb_bus_pkg::*;

	// Request fields aligned with the way read data
	logic               s0_valid;
	logic [CH_BITS-1:0] s0_channel;
	vadr_t              s0_vadr;
	asid_t              s0_asid;
	logic               s0_we;

	logic [TAG_BITS-1:0] s0_tag;
	logic [TLB_WAYS-1:0] way_hit;
	logic                hit;
	tlb_entry_t          hit_entry;

	// ========================================
	// Stage 0 issues the way read
	// ========================================
	assign rd_en_o    = grant_valid_i;
	assign rd_index_o = vadr_i[PAGE_BITS +: TLB_INDEX_BITS];

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			s0_valid <= 1'b0;
		else
			s0_valid <= grant_valid_i;
	end

	always_ff @(posedge clk_g) begin
		if (grant_valid_i) begin
			s0_channel <= grant_channel_i;
			s0_vadr    <= vadr_i;
			s0_asid    <= asid_i;
			s0_we      <= we_i;
		end
	end

	// ========================================
	// Stage 1 compares all ways
	// ========================================
	assign s0_tag = s0_vadr[VADR_BITS-1 -: TAG_BITS];

	// Global pages match any ASID
	always_comb begin
		for (int w = 0; w < TLB_WAYS; w++) begin
			way_hit[w] = way_entry_i[w].pte.v &&
				(way_entry_i[w].vpn.tag == s0_tag) &&
				((way_entry_i[w].vpn.asid == s0_asid) || way_entry_i[w].pte.g);
		end
	end

	// Lowest numbered way wins
	always_comb begin
		hit       = 1'b0;
		hit_entry = '0;
		for (int w = TLB_WAYS-1; w >= 0; w--) begin
			if (way_hit[w]) begin
				hit       = 1'b1;
				hit_entry = way_entry_i[w];
			end
		end
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= s0_valid;
	end

	always_ff @(posedge clk_g) begin
		res_channel_o <= s0_channel;
		res_hit_o     <= hit;
		if (hit) begin
			res_padr_o <= {hit_entry.pte.ppn, s0_vadr[PAGE_BITS-1:0]};
			res_rwx_o  <= hit_entry.pte.rwx;
			// Bit 1 of rwx is the write permission
			res_we_o   <= s0_we & hit_entry.pte.rwx[1];
		end else begin
			res_padr_o <= '0;
			res_rwx_o  <= '0;
			res_we_o   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tlb_maint.sv ====
// TLB maintenance unit
// Register port, holding words, entry writer and clearing sweep

`default_nettype none
`timescale 1ns/1ps

module tlb_maint (
	input  logic                                     clk_g,
	input  logic                                     rst_i,
	input  logic                                     reg_we_i,
	input  logic [stlb_bus_pkg::REG_ADDR_BITS-1:0]   reg_addr_i,
	input  tlb_entry_pkg::tlb_word_u                 reg_data_i,
	output logic                                     ready_o,
	output logic [tlb_entry_pkg::TLB_WAYS-1:0]       wr_en_o,
	output logic [tlb_entry_pkg::TLB_INDEX_BITS-1:0] wr_index_o,
	output tlb_entry_pkg::tlb_entry_t                wr_entry_o
);

	import tlb_entry_pkg::*;
	import stlb_bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_SWEEP
	} maint_state_t;

	maint_state_t state;

	// Holding words and the latched target slot
	pte_t                      pte_q;
	vpn_t                      vpn_q;
	logic [TLB_INDEX_BITS-1:0] index_q;
	logic [TLB_WAY_BITS-1:0]   way_q;

	logic [TLB_INDEX_BITS-1:0] sweep_cnt;

	logic                      reg_take;
	logic                      ctrl_take;
	logic [TLB_INDEX_BITS-1:0] ctrl_index;
	logic [TLB_WAY_BITS-1:0]   ctrl_way;
	logic                      ctrl_write;
	logic                      ctrl_clear;

	assign ready_o   = (state == ST_IDLE);
	assign reg_take  = reg_we_i && ready_o;
	assign ctrl_take = reg_take && (reg_addr_i == REG_CTRL);

	// ========================================
	// Control word decode
	// ========================================
	assign ctrl_index = reg_data_i[CTRL_INDEX_LSB +: TLB_INDEX_BITS];
	assign ctrl_way   = reg_data_i[CTRL_WAY_LSB +: TLB_WAY_BITS];
	assign ctrl_write = reg_data_i[CTRL_WRITE_BIT];
	assign ctrl_clear = reg_data_i[CTRL_CLEAR_BIT];

	always_ff @(posedge clk_g) begin
		if (reg_take && (reg_addr_i == REG_PTE))
			pte_q <= reg_data_i.pte;
		if (reg_take && (reg_addr_i == REG_VPN))
			vpn_q <= reg_data_i.vpn;
		if (ctrl_take) begin
			index_q <= ctrl_index;
			way_q   <= ctrl_way;
		end
	end

	// ========================================
	// Maintenance FSM
	// ========================================
	// Reset starts a sweep so every entry reads invalid
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state     <= ST_SWEEP;
			sweep_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ctrl_take) begin
						// Clear wins over write
						if (ctrl_clear) begin
							state     <= ST_SWEEP;
							sweep_cnt <= '0;
						end else if (ctrl_write) begin
							state <= ST_WRITE;
						end
					end
				end
				ST_WRITE: begin
					state <= ST_IDLE;
				end
				ST_SWEEP: begin
					sweep_cnt <= sweep_cnt + 1'b1;
					if (sweep_cnt == TLB_INDEX_BITS'(TLB_ENTRIES-1))
						state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Way write port
	always_comb begin
		wr_en_o    = '0;
		wr_index_o = index_q;
		wr_entry_o = '0;
		case (state)
			ST_WRITE: begin
				wr_en_o[way_q] = 1'b1;
				wr_entry_o.pte = pte_q;
				wr_entry_o.vpn = vpn_q;
			end
			ST_SWEEP: begin
				// Zero entry into every way at this index
				wr_en_o    = '1;
				wr_index_o = sweep_cnt;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== stlb_top.sv ====
// Shared TLB top level
// Arbiter, lookup pipeline, maintenance unit and four way memories

`default_nettype none
`timescale 1ns/1ps

module stlb_top (
	input  logic                                                   clk_g,
	input  logic                                                   rst_i,
	input  logic [stlb_bus_pkg::CHANNELS-1:0]                      req_i,
	input  stlb_bus_pkg::vadr_t [stlb_bus_pkg::CHANNELS-1:0]       vadr_i,
	input  tlb_entry_pkg::asid_t [stlb_bus_pkg::CHANNELS-1:0]      asid_i,
	input  logic [stlb_bus_pkg::CHANNELS-1:0]                      we_i,
	input  logic                                                   reg_we_i,
	input  logic [stlb_bus_pkg::REG_ADDR_BITS-1:0]                 reg_addr_i,
	input  tlb_entry_pkg::tlb_word_u                               reg_data_i,
	output logic                                                   ready_o,
	output logic                                                   res_valid_o,
	output logic [stlb_bus_pkg::CH_BITS-1:0]                       res_channel_o,
	output logic                                                   res_hit_o,
	output stlb_bus_pkg::padr_t                                    res_padr_o,
	output logic [2:0]                                             res_rwx_o,
	output logic                                                   res_we_o
);

	import tlb_entry_pkg::*;
	import stlb_bus_pkg::*;

	logic               grant_valid;
	logic [CH_BITS-1:0] grant_channel;

	// Granted channel request fields
	vadr_t sel_vadr;
	asid_t sel_asid;
	logic  sel_we;

	// Shared way read bus
	logic                          rd_en;
	logic [TLB_INDEX_BITS-1:0]     rd_index;
	tlb_entry_t [TLB_WAYS-1:0]     way_entry;

	// Shared way write bus
	logic [TLB_WAYS-1:0]       wr_en;
	logic [TLB_INDEX_BITS-1:0] wr_index;
	tlb_entry_t                wr_entry;

	assign sel_vadr = vadr_i[grant_channel];
	assign sel_asid = asid_i[grant_channel];
	assign sel_we   = we_i[grant_channel];

	// The result strobe retires the channel in the arbiter
	channel_arbiter u_arbiter (
		.clk_g            (clk_g),
		.rst_i            (rst_i),
		.req_i            (req_i),
		.retire_valid_i   (res_valid_o),
		.retire_channel_i (res_channel_o),
		.grant_valid_o    (grant_valid),
		.grant_channel_o  (grant_channel)
	);

	tlb_lookup u_lookup (
		.clk_g           (clk_g),
		.rst_i           (rst_i),
		.grant_valid_i   (grant_valid),
		.grant_channel_i (grant_channel),
		.vadr_i          (sel_vadr),
		.asid_i          (sel_asid),
		.we_i            (sel_we),
		.rd_en_o         (rd_en),
		.rd_index_o      (rd_index),
		.way_entry_i     (way_entry),
		.res_valid_o     (res_valid_o),
		.res_channel_o   (res_channel_o),
		.res_hit_o       (res_hit_o),
		.res_padr_o      (res_padr_o),
		.res_rwx_o       (res_rwx_o),
		.res_we_o        (res_we_o)
	);

	tlb_maint u_maint (
		.clk_g      (clk_g),
		.rst_i      (rst_i),
		.reg_we_i   (reg_we_i),
		.reg_addr_i (reg_addr_i),
		.reg_data_i (reg_data_i),
		.ready_o    (ready_o),
		.wr_en_o    (wr_en),
		.wr_index_o (wr_index),
		.wr_entry_o (wr_entry)
	);

	// ========================================
	// Way memories
	// ========================================
	for (genvar w = 0; w < TLB_WAYS; w++) begin : g_way
		tlb_way_ram u_way (
			.clk_g      (clk_g),
			.wr_en_i    (wr_en[w]),
			.wr_index_i (wr_index),
			.wr_entry_i (wr_entry),
			.rd_en_i    (rd_en),
			.rd_index_i (rd_index),
			.rd_entry_o (way_entry[w])
		);
	end

endmodule

`default_nettype wire

// ==== tb_stlb_model.svh ====
// Reference TLB model and expected-result function
// Typed compare tasks for the lookup results

`ifndef TB_STLB_MODEL_SVH
`define TB_STLB_MODEL_SVH

// Expected response of one lookup
typedef struct packed {
	logic       hit;
	padr_t      padr;
	logic [2:0] rwx;
	logic       we;
} expect_t;

// Mirror of the four ways
tlb_entry_t model_mem [TLB_WAYS][TLB_ENTRIES];

function automatic void store_entry(int way, int index, tlb_entry_t ent);
	model_mem[way][index] = ent;
endfunction

function automatic void wipe_model();
	for (int w = 0; w < TLB_WAYS; w++) begin
		for (int i = 0; i < TLB_ENTRIES; i++)
			model_mem[w][i] = '0;
	end
endfunction

// Index is va[19:14], tag is va[31:20], first matching way counts
function automatic expect_t predict_result(vadr_t va, asid_t asid, logic we);
	expect_t    res;
	tlb_entry_t ent;
	res = '0;
	for (int w = 0; w < TLB_WAYS; w++) begin
		ent = model_mem[w][va[19:14]];
		if (!res.hit && ent.pte.v && ent.vpn.tag == va[31:20] &&
			(ent.pte.g || ent.vpn.asid == asid)) begin
			res.hit  = 1'b1;
			res.padr = {ent.pte.ppn, va[13:0]};
			res.rwx  = ent.pte.rwx;
			// rwx[1] is the write permission
			res.we   = we & ent.pte.rwx[1];
		end
	end
	return res;
endfunction

// ========================================
// Compare tasks
// ========================================
task automatic check_padr(string name, padr_t got, padr_t exp);
	if (got !== exp) begin
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_rwx(string name, logic [2:0] got, logic [2:0] exp);
	if (got !== exp) begin
		$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_flag(string name, logic got, logic exp);
	if (got !== exp) begin
		$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

`endif

// ==== tb_stlb.sv ====
// Testbench for the shared TLB
// Clock, reset, register and lookup stimulus, result watcher

`default_nettype none
`timescale 1ns/1ps

module tb_stlb;

	import tlb_entry_pkg::*;
	import stlb_bus_pkg::*;

	localparam int TIMEOUT = 200;

	logic                     clk_g;
	logic                     rst_i;
	logic [CHANNELS-1:0]      req_i;
	vadr_t [CHANNELS-1:0]     vadr_i;
	asid_t [CHANNELS-1:0]     asid_i;
	logic [CHANNELS-1:0]      we_i;
	logic                     reg_we_i;
	logic [REG_ADDR_BITS-1:0] reg_addr_i;
	tlb_word_u                reg_data_i;
	logic                     ready_o;
	logic                     res_valid_o;
	logic [CH_BITS-1:0]       res_channel_o;
	logic                     res_hit_o;
	padr_t                    res_padr_o;
	logic [2:0]               res_rwx_o;
	logic                     res_we_o;

	`include "tb_stlb_model.svh"

	// Lookups issued by the driver and results taken by the watcher
	expect_t exp_res [CHANNELS];
	int      issued_cnt [CHANNELS];
	int      seen_cnt [CHANNELS];
	vadr_t   page_va [$];
	asid_t   page_asid [$];

	stlb_top dut (.*);

	always #4 clk_g = ~clk_g;

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (ready_o !== 1'b1) begin
			if (n == TIMEOUT) begin
				$display("ready_o stayed low for %0d cycles", TIMEOUT);
				abort_run();
			end
			@(posedge clk_g);
			#1;
			n++;
		end
	endtask

	task automatic reg_write(logic [REG_ADDR_BITS-1:0] addr, tlb_word_u data);
		reg_we_i   = 1'b1;
		reg_addr_i = addr;
		reg_data_i = data;
		@(posedge clk_g);
		#1;
		reg_we_i = 1'b0;
	endtask

	task automatic write_entry(int way, int index, pte_t pte, vpn_t vpn);
		tlb_word_u  word;
		tlb_entry_t ent;
		wait_ready();
		word.pte = pte;
		reg_write(REG_PTE, word);
		word.vpn = vpn;
		reg_write(REG_VPN, word);
		word = '0;
		word[CTRL_INDEX_LSB +: TLB_INDEX_BITS] = TLB_INDEX_BITS'(index);
		word[CTRL_WAY_LSB +: TLB_WAY_BITS]     = TLB_WAY_BITS'(way);
		word[CTRL_WRITE_BIT]                   = 1'b1;
		reg_write(REG_CTRL, word);
		wait_ready();
		ent.pte = pte;
		ent.vpn = vpn;
		store_entry(way, index, ent);
	endtask

	task automatic clear_tlb();
		tlb_word_u word;
		wait_ready();
		word = '0;
		word[CTRL_CLEAR_BIT] = 1'b1;
		reg_write(REG_CTRL, word);
		wait_ready();
		wipe_model();
	endtask

	// Raises one channel's request; the expectation is fixed here
	task automatic start_lookup(int ch, vadr_t va, asid_t asid, logic we);
		vadr_i[ch]  = va;
		asid_i[ch]  = asid;
		we_i[ch]    = we;
		exp_res[ch] = predict_result(va, asid, we);
		issued_cnt[ch]++;
		req_i[ch] = 1'b1;
	endtask

	// Drops each request right after its result pulse
	task automatic wait_results();
		int n;
		n = 0;
		while (req_i != '0) begin
			if (n == TIMEOUT) begin
				$display("requests %b got no result in %0d cycles", req_i, TIMEOUT);
				abort_run();
			end
			@(posedge clk_g);
			#1;
			for (int ch = 0; ch < CHANNELS; ch++) begin
				if (seen_cnt[ch] == issued_cnt[ch])
					req_i[ch] = 1'b0;
			end
			n++;
		end
	endtask

	task automatic lookup_one(int ch, vadr_t va, asid_t asid, logic we);
		start_lookup(ch, va, asid, we);
		wait_results();
	endtask

	// ========================================
	// Result watcher
	// ========================================
	always @(negedge clk_g) begin
		if (rst_i === 1'b0 && res_valid_o === 1'b1) begin
			if (seen_cnt[res_channel_o] == issued_cnt[res_channel_o]) begin
				$display("result for channel %0d at %0t ns without an open request",
					res_channel_o, $time);
				abort_run();
			end else begin
				check_flag("res_hit_o", res_hit_o, exp_res[res_channel_o].hit);
				check_padr("res_padr_o", res_padr_o, exp_res[res_channel_o].padr);
				check_rwx("res_rwx_o", res_rwx_o, exp_res[res_channel_o].rwx);
				check_flag("res_we_o", res_we_o, exp_res[res_channel_o].we);
				seen_cnt[res_channel_o]++;
			end
		end
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		pte_t  pte;
		vpn_t  vpn;
		int    idx;
		int    pick;
		vadr_t va;
		clk_g      = 1'b0;
		rst_i      = 1'b1;
		req_i      = '0;
		vadr_i     = '0;
		asid_i     = '0;
		we_i       = '0;
		reg_we_i   = 1'b0;
		reg_addr_i = '0;
		reg_data_i = '0;
		for (int ch = 0; ch < CHANNELS; ch++) begin
			issued_cnt[ch] = 0;
			seen_cnt[ch]   = 0;
			exp_res[ch]    = '0;
		end
		wipe_model();
		void'($urandom(32'h31d99bc9));
		repeat (5) @(posedge clk_g);
		#1;
		rst_i = 1'b0;

		// Empty TLB after the reset sweep
		wait_ready();
		repeat (8) begin
			for (int ch = 0; ch < CHANNELS; ch++)
				start_lookup(ch, $urandom(), ASID_BITS'($urandom()), 1'($urandom()));
			wait_results();
		end

		// Random entries, then one lookup per page
		for (int i = 0; i < 16; i++) begin
			pte      = '0;
			pte.v    = 1'b1;
			pte.g    = 1'($urandom());
			pte.rwx  = 3'($urandom());
			pte.ppn  = PPN_BITS'($urandom());
			vpn      = '0;
			vpn.asid = ASID_BITS'($urandom());
			vpn.tag  = TAG_BITS'($urandom());
			idx      = $urandom_range(TLB_ENTRIES-1, 0);
			write_entry(i % TLB_WAYS, idx, pte, vpn);
			page_va.push_back({vpn.tag, TLB_INDEX_BITS'(idx), PAGE_BITS'($urandom())});
			page_asid.push_back(vpn.asid);
		end
		foreach (page_va[i])
			lookup_one(i % CHANNELS, page_va[i], page_asid[i], 1'b0);

		// ASID mismatch, first private then global
		pte      = '0;
		pte.v    = 1'b1;
		pte.rwx  = 3'b101;
		pte.ppn  = PPN_BITS'($urandom());
		vpn      = '0;
		vpn.asid = 8'h5a;
		vpn.tag  = TAG_BITS'($urandom());
		va       = {vpn.tag, 6'd33, 14'h0abc};
		write_entry(2, 33, pte, vpn);
		lookup_one(1, va, 8'h5b, 1'b0);
		lookup_one(2, va, 8'h5a, 1'b0);
		pte.g = 1'b1;
		write_entry(2, 33, pte, vpn);
		lookup_one(3, va, 8'h5b, 1'b0);
		page_va.push_back(va);
		page_asid.push_back(8'h5a);

		// Write permission, read-only page then read-write page
		for (int k = 0; k < 2; k++) begin
			pte.g   = 1'b0;
			pte.rwx = (k == 0) ? 3'b100 : 3'b110;
			vpn.tag = TAG_BITS'($urandom());
			va      = {vpn.tag, TLB_INDEX_BITS'(17 + k), PAGE_BITS'($urandom())};
			write_entry(3 - k, 17 + k, pte, vpn);
			lookup_one(0, va, 8'h5a, 1'b1);
			lookup_one(2, va, 8'h5a, 1'b0);
			page_va.push_back(va);
			page_asid.push_back(8'h5a);
		end

		// All channels at once on known pages
		repeat (20) begin
			for (int ch = 0; ch < CHANNELS; ch++) begin
				pick = $urandom_range(page_va.size()-1, 0);
				start_lookup(ch, page_va[pick], page_asid[pick], 1'($urandom()));
			end
			wait_results();
		end

		// Every page misses after a clear
		clear_tlb();
		foreach (page_va[i])
			lookup_one(i % CHANNELS, page_va[i], page_asid[i], 1'b1);

		// Quiet window longer than the pipeline so a stray result still shows
		repeat (4) @(posedge clk_g);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
tlb_entry_pkg.sv
stlb_bus_pkg.sv
tlb_way_ram.sv
channel_arbiter.sv
tlb_lookup.sv
tlb_maint.sv
stlb_top.sv
tb_stlb.sv
